// File: Makefile
.PHONY: all run clean

all: run

obj_dir/Vfetch_tb: project.f verilog/*.sv verification/fetch_tb.sv
	verilator --binary --timing --timescale 1ns/1ns --top-module fetch_tb -f project.f

run: obj_dir/Vfetch_tb
	./obj_dir/Vfetch_tb | tee sim.log
	grep -q "^Verification passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: project.f
verilog/fetch_pkg.sv
verilog/fetch_addr_sel.sv
verilog/icache_bank.sv
verilog/refill_beat_counter.sv
verilog/refill_fsm.sv
verilog/fetch_top.sv
verification/fetch_tb.sv

// File: verification/fetch_tb.sv
`timescale 1ns/1ns

module fetch_tb;

    import fetch_pkg::*;

    localparam int CYCLES_PER_TEST = 200;
    localparam int MAX_TESTS       = 64;

    logic              clk      = 1'b0;
    logic              mem_ack  = 1'b0;
    logic [BEAT_W-1:0] mem_data = '0;
    logic              rst_n;
    cf_redirect_t      redirect;
    logic              fetch_take;
    logic              fetch_valid;
    logic [LINE_W-1:0] line_even;
    logic [LINE_W-1:0] line_odd;
    logic [31:0]       fetch_addr;
    logic              mem_req;
    logic [31:0]       mem_addr;

    string       t_name  [MAX_TESTS];
    string       t_op    [MAX_TESTS];
    logic [31:0] t_value [MAX_TESTS];
    logic [31:0] t_base  [MAX_TESTS];
    int          num_tests;
    int          cycle_limit = CYCLES_PER_TEST;
    int          cycles;
    int          mismatches;
    int          protocol_errors;
    int          other_errors;
    int          req_rises;
    logic [31:0] lfsr = 32'hff04;

    // reference model of both pointers and of the valid bits and tags per bank and set
    logic [31:0] m_even;
    logic [31:0] m_odd;
    logic        m_valid [2][SETS_PER_BANK];
    logic [23:0] m_tag   [2][SETS_PER_BANK];

    fetch_top u_fetch_top (
        .clk           (clk),
        .rst_n_i       (rst_n),
        .redirect_i    (redirect),
        .fetch_take_i  (fetch_take),
        .mem_ack_i     (mem_ack),
        .mem_data_i    (mem_data),
        .fetch_valid_o (fetch_valid),
        .line_even_o   (line_even),
        .line_odd_o    (line_odd),
        .fetch_addr_o  (fetch_addr),
        .mem_req_o     (mem_req),
        .mem_addr_o    (mem_addr)
    );

    always #20 clk = ~clk;

    //////////////////////////////////////////////////
    // memory and reference model
    //////////////////////////////////////////////////

    function automatic logic [31:0] mem_word(input logic [31:0] a, input int k);
        return a ^ (32'(k) * 32'h01010101) ^ 32'h5a5a0000;
    endfunction

    function automatic logic [LINE_W-1:0] mem_line(input logic [31:0] a);
        logic [LINE_W-1:0] l;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            l[k*BEAT_W +: BEAT_W] = mem_word(a, k);   // beat 0 in the low word
        end
        return l;
    endfunction

    // bit 4 selects the bank and bits 7:5 the set
    function automatic logic model_hit(input logic [31:0] p);
        return m_valid[p[4]][p[7:5]] && (m_tag[p[4]][p[7:5]] == p[31:8]);
    endfunction

    task automatic model_fill(input logic [31:0] p);
        m_valid[p[4]][p[7:5]] = 1'b1;
        m_tag[p[4]][p[7:5]]   = p[31:8];
    endtask

    task automatic model_redirect(input logic [31:0] tgt);
        logic [31:0] line_a;
        line_a = {tgt[31:4], 4'h0};
        m_even = tgt[4] ? line_a + 32'd16 : line_a;   // bank past the target gets the next line
        m_odd  = tgt[4] ? line_a : line_a + 32'd16;
    endtask

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output int bits);
        bits = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = (bits << 1) | int'(lfsr[0]);
        end
    endtask

    // one beat of the four-phase memory handshake
    task automatic serve_beat();
        int delay;
        while (mem_req !== 1'b1) @(negedge clk);
        draw_bits(2, delay);
        repeat (delay) @(negedge clk);
        mem_data = mem_word({mem_addr[31:4], 4'h0}, int'(mem_addr[3:2]));
        mem_ack  = 1'b1;
        while (mem_req === 1'b1) @(negedge clk);
        draw_bits(2, delay);
        repeat (delay) @(negedge clk);   // ack may trail the falling request
        mem_ack  = 1'b0;
    endtask

    always begin
        @(negedge clk);
        serve_beat();
    end

    always @(posedge mem_req) begin
        req_rises++;
        if (mem_ack) begin
            protocol_errors++;
            $display("protocol error: mem_req_o rose while mem_ack_i was still high");
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("errors: %0d mismatches, %0d protocol, %0d other, 1 timeout",
                     mismatches, protocol_errors, other_errors);
            $display("Verification failed");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // stimulus and checks
    //////////////////////////////////////////////////

    task automatic check_value(input string name, input string what,
                               input logic [LINE_W-1:0] expected,
                               input logic [LINE_W-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("mismatch %s %s: expected %h actual %h", name, what, expected, actual);
        end
    endtask

    task automatic check_pair(input string name, input logic [31:0] base);
        check_value(name, "fetch_valid_o", 128'(1), 128'(fetch_valid));
        check_value(name, "fetch_addr_o", 128'(base), 128'(fetch_addr));
        check_value(name, "line_even_o", mem_line(m_even), line_even);
        check_value(name, "line_odd_o", mem_line(m_odd), line_odd);
    endtask

    task automatic load_tests();
        int          fd;
        string       line;
        string       name;
        string       op;
        logic [31:0] value;
        logic [31:0] base;
        fd = $fopen("verification/fetch_tests.txt", "r");
        if (fd == 0) begin
            other_errors++;
            $display("cannot open verification/fetch_tests.txt");
        end else begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                if ($fgets(line, fd) > 0 && line.substr(0, 0) != "#" &&
                    $sscanf(line, "%s %s %h %h", name, op, value, base) == 4) begin
                    t_name[num_tests]  = name;
                    t_op[num_tests]    = op;
                    t_value[num_tests] = value;
                    t_base[num_tests]  = base;
                    num_tests++;
                end
            end
            $fclose(fd);
        end
    endtask

    // redirect or take held for one cycle from a falling edge
    task automatic apply_op(input string name, input string op, input logic [31:0] v);
        @(negedge clk);
        if (op == "init" || op == "all") begin
            redirect.init_vld = 1'b1;
            redirect.init_tgt = v;
        end
        if (op == "resteer" || op == "both" || op == "all") begin
            redirect.resteer_vld = 1'b1;
            redirect.wb_tgt      = (op == "all") ? v + 32'h200 : v;
        end
        if (op == "branch" || op == "both" || op == "all") begin
            redirect.branch_vld = 1'b1;
            redirect.bp_tgt     = (op == "branch") ? v : v + 32'h400;  // decoy unless alone
        end
        if (op == "take") begin
            fetch_take = 1'b1;
            m_even += 32'd32;
            m_odd  += 32'd32;
        end else if (redirect.init_vld || redirect.resteer_vld || redirect.branch_vld) begin
            model_redirect(v);
        end else if (op != "hold") begin
            other_errors++;
            $display("unknown operation %s in test %s", op, name);
        end
        @(negedge clk);
        redirect   = '0;
        fetch_take = 1'b0;
    endtask

    task automatic run_test(input string name, input string op, input logic [31:0] v,
                            input logic [31:0] base);
        int rises_before;
        int refills;
        rises_before = req_rises;
        apply_op(name, op, v);
        refills = (model_hit(m_even) ? 0 : 1) + (model_hit(m_odd) ? 0 : 1);
        model_fill(m_even);
        model_fill(m_odd);
        while (!fetch_valid) @(negedge clk);
        if (op == "hold") begin
            repeat (v) begin
                check_pair(name, base);
                @(negedge clk);
            end
        end
        check_pair(name, base);
        check_value(name, "memory requests", 128'(4 * refills), 128'(req_rises - rises_before));
    endtask

    initial begin
        rst_n      = 1'b0;
        redirect   = '0;
        fetch_take = 1'b0;
        m_even     = 32'd0;
        m_odd      = 32'd16;
        for (int s = 0; s < SETS_PER_BANK; s++) begin
            m_valid[0][s] = 1'b0;
            m_valid[1][s] = 1'b0;
        end
        load_tests();
        cycle_limit = CYCLES_PER_TEST * (num_tests + 1);
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        run_test("reset_pair", "hold", 32'd0, 32'd0);   // pair 0/16 fills straight after reset
        for (int t = 0; t < num_tests; t++) begin
            run_test(t_name[t], t_op[t], t_value[t], t_base[t]);
        end
        if (num_tests == 0) begin
            other_errors++;
            $display("no test vectors were read");
        end
        $display("errors: %0d mismatches, %0d protocol, %0d other",
                 mismatches, protocol_errors, other_errors);
        if (mismatches + protocol_errors + other_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verification/fetch_tests.txt
# columns: name, operation, value (hex), expected fetch_addr_o (hex)
# operations: init resteer branch both(resteer+branch) all(init+resteer+branch) take hold
# for hold the value is the number of cycles with fetch_take_i low
init_even      init     00001040  00001040
init_odd       init     00002074  00002070
take_1         take     00000000  00002090
take_2         take     00000000  000020b0
take_3         take     00000000  000020d0
revisit_even   init     00001040  00001040
revisit_odd    init     00002074  00002070
revisit_take   take     00000000  00002090
resteer_only   resteer  00003000  00003000
branch_only    branch   00001058  00001050
prio_all       all      00004010  00004010
prio_all_even  all      00004440  00004440
prio_both      both     00005000  00005000
prio_both_odd  both     0000503c  00005030
hold_pair      hold     00000030  00005030
take_after     take     00000000  00005050
evict_a        init     00000100  00000100
evict_b        init     00005000  00005000
evict_c        init     00000100  00000100
zero_line      init     00000000  00000000
branch_dbl     branch   0000601c  00006010
hold_again     hold     00000014  00006010
take_final     take     00000000  00006030

// File: verilog/fetch_addr_sel.sv
`timescale 1ns/1ns

module fetch_addr_sel (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  fetch_pkg::cf_redirect_t redirect_i,
    input  logic                   take_i,       // decoder took the current pair
    output fetch_pkg::fetch_addr_u even_fip_o,
    output fetch_pkg::fetch_addr_u odd_fip_o
);

    import fetch_pkg::*;

    logic        redirect;
    fetch_addr_u tgt;        // winning redirect target
    fetch_addr_u tgt_line;   // target aligned to its line
    fetch_addr_u tgt_next;   // line after the target
    fetch_addr_u redir_even;
    fetch_addr_u redir_odd;
    fetch_addr_u even_q;
    fetch_addr_u odd_q;

    //////////////////////////////////////////////////
    // redirect priority
    //////////////////////////////////////////////////

    always_comb begin
        redirect = redirect_i.init_vld | redirect_i.resteer_vld | redirect_i.branch_vld;
        if (redirect_i.init_vld) begin
            tgt.raw = redirect_i.init_tgt;
        end else if (redirect_i.resteer_vld) begin
            tgt.raw = redirect_i.wb_tgt;
        end else begin
            tgt.raw = redirect_i.bp_tgt;
        end
    end

    //////////////////////////////////////////////////
    // bank pointer derivation
    //////////////////////////////////////////////////

    always_comb begin
        tgt_line          = tgt;
        tgt_line.f.offset = '0;
        tgt_next.raw      = tgt_line.raw + 32'(LINE_BYTES);

        // the bank past the target gets the following line
        if (tgt.f.bank) begin
            redir_odd  = tgt_line;
            redir_even = tgt_next;
        end else begin
            redir_even = tgt_line;
            redir_odd  = tgt_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            even_q.raw <= '0;
            odd_q.raw  <= 32'(LINE_BYTES);
        end else if (redirect) begin       // wins over a take in the same cycle
            even_q <= redir_even;
            odd_q  <= redir_odd;
        end else if (take_i) begin
            even_q.raw <= even_q.raw + 32'(2 * LINE_BYTES);
            odd_q.raw  <= odd_q.raw + 32'(2 * LINE_BYTES);
        end
    end

    assign even_fip_o = even_q;
    assign odd_fip_o  = odd_q;

endmodule

// File: verilog/fetch_pkg.sv
package fetch_pkg;

    //////////////////////////////////////////////////
    // geometry
    //////////////////////////////////////////////////

    localparam int LINE_BYTES     = 16;   // one fetch line
    localparam int BEATS_PER_LINE = 4;    // 32-bit words per refill
    localparam int SETS_PER_BANK  = 8;
    localparam int LINE_W         = 128;
    localparam int BEAT_W         = 32;

    //////////////////////////////////////////////////
    // fetch address
    //////////////////////////////////////////////////

    // field view, msb first
    typedef struct packed {
        logic [23:0] tag;
        logic [2:0]  index;
        logic        bank;    // bit 4, picks even or odd bank
        logic [3:0]  offset;  // byte within the line
    } fetch_fields_t;

    // raw view for arithmetic, field view for lookup
    typedef union packed {
        logic [31:0]   raw;
        fetch_fields_t f;
    } fetch_addr_u;

    //////////////////////////////////////////////////
    // control flow and refill transport
    //////////////////////////////////////////////////

    // redirect sources, init > resteer > branch
    typedef struct packed {
        logic        init_vld;
        logic        resteer_vld;
        logic        branch_vld;
        logic [31:0] init_tgt;
        logic [31:0] wb_tgt;    // write-back resteer target
        logic [31:0] bp_tgt;    // predicted target
    } cf_redirect_t;

    // one completed line going into the banks
    typedef struct packed {
        logic              wr;
        logic              bank;
        logic [31:0]       addr;
        logic [LINE_W-1:0] data;
    } fill_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_PICK,
        ST_REQ_HIGH,
        ST_WAIT_ACK_LOW,
        ST_WRITE
    } refill_state_e;

endpackage

// File: verilog/fetch_top.sv
`timescale 1ns/1ns

module fetch_top (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  fetch_pkg::cf_redirect_t       redirect_i,
    input  logic                          fetch_take_i,
    input  logic                          mem_ack_i,
    input  logic [fetch_pkg::BEAT_W-1:0] mem_data_i,
    output logic                          fetch_valid_o,
    output logic [fetch_pkg::LINE_W-1:0] line_even_o,
    output logic [fetch_pkg::LINE_W-1:0] line_odd_o,
    output logic [31:0]                   fetch_addr_o,
    output logic                          mem_req_o,
    output logic [31:0]                   mem_addr_o
);

    import fetch_pkg::*;

    fetch_addr_u       even_fip;
    fetch_addr_u       odd_fip;
    fill_t             fill;
    logic              even_hit;
    logic              odd_hit;
    logic              busy;
    logic              take;
    logic              beat_valid;
    logic              beat_clear;
    logic [1:0]        beat_num;
    logic              beat_last;
    logic [LINE_W-1:0] refill_line;

    //////////////////////////////////////////////////
    // decoder side
    //////////////////////////////////////////////////

    assign fetch_valid_o = even_hit && odd_hit && !busy;
    assign take          = fetch_take_i && fetch_valid_o;   // ignored while not valid
    assign fetch_addr_o  = (even_fip.raw < odd_fip.raw) ? even_fip.raw : odd_fip.raw;

    fetch_addr_sel u_fetch_addr_sel (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .redirect_i (redirect_i),
        .take_i     (take),
        .even_fip_o (even_fip),
        .odd_fip_o  (odd_fip)
    );

    icache_bank #(.BANK(1'b0)) u_bank_even (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fip_i   (even_fip),
        .fill_i  (fill),
        .hit_o   (even_hit),
        .line_o  (line_even_o)
    );

    icache_bank #(.BANK(1'b1)) u_bank_odd (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .fip_i   (odd_fip),
        .fill_i  (fill),
        .hit_o   (odd_hit),
        .line_o  (line_odd_o)
    );

    //////////////////////////////////////////////////
    // refill path
    //////////////////////////////////////////////////

    refill_fsm u_refill_fsm (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .even_hit_i   (even_hit),
        .odd_hit_i    (odd_hit),
        .even_fip_i   (even_fip),
        .odd_fip_i    (odd_fip),
        .mem_ack_i    (mem_ack_i),
        .beat_num_i   (beat_num),
        .last_i       (beat_last),
        .line_i       (refill_line),
        .mem_req_o    (mem_req_o),
        .mem_addr_o   (mem_addr_o),
        .beat_valid_o (beat_valid),
        .clear_o      (beat_clear),
        .fill_o       (fill),
        .busy_o       (busy)
    );

    refill_beat_counter u_beat_counter (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .clear_i      (beat_clear),
        .beat_valid_i (beat_valid),
        .beat_data_i  (mem_data_i),
        .beat_num_o   (beat_num),
        .last_o       (beat_last),
        .line_o       (refill_line)
    );

endmodule

// File: verilog/icache_bank.sv
`timescale 1ns/1ns

module icache_bank #(
    parameter logic BANK = 1'b0    // 0 for the even bank, 1 for the odd bank
) (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  fetch_pkg::fetch_addr_u        fip_i,
    input  fetch_pkg::fill_t              fill_i,
    output logic                          hit_o,
    output logic [fetch_pkg::LINE_W-1:0] line_o
);

    import fetch_pkg::*;

    //////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////

    logic [SETS_PER_BANK-1:0] valid_q;
    logic [23:0]              tag_mem  [SETS_PER_BANK];
    logic [LINE_W-1:0]        line_mem [SETS_PER_BANK];

    fetch_addr_u fill_addr;
    logic        fill_we;
    logic [2:0]  rd_idx;
    logic [23:0] rd_tag;
    logic        rd_valid;

    // fill is broadcast to both banks, only the matching one takes it
    assign fill_addr.raw = fill_i.addr;
    assign fill_we       = fill_i.wr && (fill_i.bank == BANK);

    //////////////////////////////////////////////////
    // fill write
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_q <= '0;
        end else if (fill_we) begin
            valid_q[fill_addr.f.index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we) begin
            tag_mem[fill_addr.f.index]  <= fill_addr.f.tag;
            line_mem[fill_addr.f.index] <= fill_i.data;
        end
    end

    //////////////////////////////////////////////////
    // lookup
    //////////////////////////////////////////////////

    assign rd_idx   = fip_i.f.index;
    assign rd_tag   = tag_mem[rd_idx];
    assign rd_valid = valid_q[rd_idx];

    always_comb begin
        hit_o  = rd_valid && (rd_tag == fip_i.f.tag);  // direct mapped, one way
        line_o = line_mem[rd_idx];
    end

endmodule

// File: verilog/refill_beat_counter.sv
`timescale 1ns/1ns

module refill_beat_counter (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          clear_i,
    input  logic                          beat_valid_i,   // word accepted this cycle
    input  logic [fetch_pkg::BEAT_W-1:0] beat_data_i,
    output logic [1:0]                    beat_num_o,
    output logic                          last_o,
    output logic [fetch_pkg::LINE_W-1:0] line_o
);

    import fetch_pkg::*;

    logic [1:0]        cnt_q;
    logic              last_q;
    logic [LINE_W-1:0] buf_q;    // assembled line, beat 0 in the low word

    always_ff @(posedge clk) begin
        if (!rst_n_i || clear_i) begin
            cnt_q  <= '0;
            last_q <= 1'b0;
        end else if (beat_valid_i) begin
            cnt_q  <= cnt_q + 2'd1;                              // wraps after beat 3
            last_q <= (cnt_q == 2'(BEATS_PER_LINE - 1));
        end
    end

    always_ff @(posedge clk) begin
        if (beat_valid_i) begin
            buf_q[cnt_q*BEAT_W +: BEAT_W] <= beat_data_i;
        end
    end

    assign beat_num_o = cnt_q;
    assign last_o     = last_q;
    assign line_o     = buf_q;

endmodule

// File: verilog/refill_fsm.sv
`timescale 1ns/1ns

module refill_fsm (
    input  logic                          clk,
    input  logic                          rst_n_i,
    input  logic                          even_hit_i,
    input  logic                          odd_hit_i,
    input  fetch_pkg::fetch_addr_u        even_fip_i,
    input  fetch_pkg::fetch_addr_u        odd_fip_i,
    input  logic                          mem_ack_i,
    input  logic [1:0]                    beat_num_i,
    input  logic                          last_i,     // all four beats are in
    input  logic [fetch_pkg::LINE_W-1:0] line_i,
    output logic                          mem_req_o,
    output logic [31:0]                   mem_addr_o,
    output logic                          beat_valid_o,
    output logic                          clear_o,
    output fetch_pkg::fill_t              fill_o,
    output logic                          busy_o
);

    import fetch_pkg::*;

    refill_state_e state_q;
    refill_state_e state_d;
    fetch_addr_u   line_addr_q;    // line being refilled
    fetch_addr_u   pick_addr;

    //////////////////////////////////////////////////
    // victim choice, even bank first
    //////////////////////////////////////////////////

    always_comb begin
        pick_addr          = even_hit_i ? odd_fip_i : even_fip_i;
        pick_addr.f.offset = '0;
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (!even_hit_i || !odd_hit_i) begin
                    state_d = ST_PICK;
                end
            end
            ST_PICK: begin
                // a redirect may have removed the miss
                state_d = (even_hit_i && odd_hit_i) ? ST_IDLE : ST_REQ_HIGH;
            end
            ST_REQ_HIGH: begin
                if (mem_ack_i) begin
                    state_d = ST_WAIT_ACK_LOW;    // word taken on this edge
                end
            end
            ST_WAIT_ACK_LOW: begin
                if (!mem_ack_i) begin
                    state_d = last_i ? ST_WRITE : ST_REQ_HIGH;
                end
            end
            ST_WRITE: state_d = ST_IDLE;          // lookup again next cycle
            default:  state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_PICK) begin
            line_addr_q <= pick_addr;
        end
    end

    //////////////////////////////////////////////////
    // memory port and fill
    //////////////////////////////////////////////////

    assign mem_req_o    = (state_q == ST_REQ_HIGH);
    assign mem_addr_o   = line_addr_q.raw + {28'd0, beat_num_i, 2'b00};
    assign beat_valid_o = (state_q == ST_REQ_HIGH) && mem_ack_i;
    assign clear_o      = (state_q == ST_WRITE);  // counter back to 0 for the next line
    assign busy_o       = (state_q == ST_WRITE);

    always_comb begin
        fill_o.wr   = (state_q == ST_WRITE);
        fill_o.bank = line_addr_q.f.bank;
        fill_o.addr = line_addr_q.raw;
        fill_o.data = line_i;
    end

endmodule
